// ==== Bender.yml ====
package:
  name: mult_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/core_types_pkg.sv
      - design/mult_pkg.sv
      - design/mult_operand_prep.sv
      - design/mult_stage.sv
      - design/mult_result_stage.sv
      - design/mult_unit.sv

  - target: test
    include_dirs:
      - design
    files:
      - testbench/mult_unit_tb.sv

// ==== compile.f ====
+incdir+design
design/core_types_pkg.sv
design/mult_pkg.sv
design/mult_operand_prep.sv
design/mult_stage.sv
design/mult_result_stage.sv
design/mult_unit.sv
testbench/mult_unit_tb.sv

// ==== design/core_types_pkg.sv ====
`include "mult_params.svh"

package core_types_pkg;

    // tag of a physical register, the rename target of a destination
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    typedef logic [`BMASK_WIDTH-1:0] bmask_t;   // a set bit marks a dependence on that branch

    // broadcast by the branch unit once a branch has been resolved
    typedef struct packed {
        logic   valid;
        logic   mispredict;
        bmask_t branch_bit;    // one-hot, names the resolved branch
    } branch_resolve_t;

    // result packet presented to the common data bus
    typedef struct packed {
        phys_reg_t        tag;
        logic [`XLEN-1:0] value;
    } cdb_packet_t;

    // true when a packet with mask bm has to be dropped by this broadcast
    function automatic logic bm_squash(input bmask_t bm, input branch_resolve_t br);
        return br.valid & br.mispredict & (|(bm & br.branch_bit));
    endfunction

    // a correctly predicted branch no longer constrains anything behind it
    function automatic bmask_t bm_clear(input bmask_t bm, input branch_resolve_t br);
        bmask_t cleared;
        cleared = bm;
        if (br.valid && !br.mispredict) begin
            cleared = bm & ~br.branch_bit;
        end
        return cleared;
    endfunction

endpackage

// ==== design/mult_operand_prep.sv ====
`timescale 1ns/1ps
`include "mult_params.svh"

module mult_operand_prep (
    input  logic                            issue_valid,
    input  mult_pkg::mult_issue_t           issue_pkt,
    input  core_types_pkg::branch_resolve_t branch_resolve,
    output mult_pkg::mult_stage_t           stage_pkt
);

    logic [2*`XLEN-1:0] src1_ext;
    logic [2*`XLEN-1:0] src2_ext;
    logic               squash_hit;

    // the multiplicand is signed for every variant except MULHU
    always_comb begin
        case (issue_pkt.func)
            mult_pkg::MUL, mult_pkg::MULH, mult_pkg::MULHSU: begin
                src1_ext = {{`XLEN{issue_pkt.src1[`XLEN-1]}}, issue_pkt.src1};
            end
            default: begin
                src1_ext = {{`XLEN{1'b0}}, issue_pkt.src1};
            end
        endcase
    end

    // the multiplier is only signed when both operands are
    always_comb begin
        case (issue_pkt.func)
            mult_pkg::MUL, mult_pkg::MULH: begin
                src2_ext = {{`XLEN{issue_pkt.src2[`XLEN-1]}}, issue_pkt.src2};
            end
            default: begin
                src2_ext = {{`XLEN{1'b0}}, issue_pkt.src2};
            end
        endcase
    end

    // a broadcast in the issue cycle already counts for this packet
    assign squash_hit = core_types_pkg::bm_squash(issue_pkt.bm, branch_resolve);

    always_comb begin
        stage_pkt.valid    = issue_valid & ~squash_hit;
        stage_pkt.sum.full = '0;                // nothing accumulated yet
        stage_pkt.mplier   = src2_ext;
        stage_pkt.mcand    = src1_ext;
        stage_pkt.dest     = issue_pkt.dest;
        stage_pkt.bm       = core_types_pkg::bm_clear(issue_pkt.bm, branch_resolve);
        stage_pkt.func     = issue_pkt.func;
    end

endmodule

// ==== design/mult_params.svh ====
`ifndef MULT_PARAMS_SVH
`define MULT_PARAMS_SVH

// operand width of the integer datapath
`define XLEN 32

// accumulate stages in the multiplier, legal values are 2, 4 or 8
`define MULT_STAGES 4

`define PHYS_REGS 64    // size of the physical register file
`define BMASK_WIDTH 4   // unresolved branches tracked at once

`endif

// ==== design/mult_pkg.sv ====
`include "mult_params.svh"

package mult_pkg;

    // RISC-V M extension multiply variants
    typedef enum logic [1:0] {
        MUL    = 2'd0,  // low half, operands signed
        MULH   = 2'd1,  // high half, signed x signed
        MULHSU = 2'd2,  // high half, signed x unsigned
        MULHU  = 2'd3   // high half, unsigned x unsigned
    } mult_func_e;

    // packet handed over by the issue stage
    typedef struct packed {
        logic [`XLEN-1:0]          src1;
        logic [`XLEN-1:0]          src2;
        mult_func_e                func;
        core_types_pkg::phys_reg_t dest;
        core_types_pkg::bmask_t    bm;
    } mult_issue_t;

    typedef struct packed {
        logic [`XLEN-1:0] hi;
        logic [`XLEN-1:0] lo;
    } mult_halves_t;

    // the accumulators work on the whole word, the result select on its halves
    typedef union packed {
        logic [2*`XLEN-1:0] full;
        mult_halves_t       half;
    } mult_product_u;

    // contents of one pipeline register in the multiplier
    typedef struct packed {
        logic                      valid;
        mult_product_u             sum;     // partial products accumulated so far
        logic [2*`XLEN-1:0]        mplier;  // remaining multiplier bits, lsb first
        logic [2*`XLEN-1:0]        mcand;   // multiplicand aligned to the next chunk
        core_types_pkg::phys_reg_t dest;
        core_types_pkg::bmask_t    bm;
        mult_func_e                func;
    } mult_stage_t;

endpackage

// ==== design/mult_result_stage.sv ====
`timescale 1ns/1ps
`include "mult_params.svh"

module mult_result_stage (
    input  logic                            clock,
    input  logic                            arst_n,
    input  mult_pkg::mult_stage_t           stage_in,
    input  core_types_pkg::branch_resolve_t branch_resolve,
    input  logic                            cdb_grant,
    output logic                            cdb_req,
    output core_types_pkg::cdb_packet_t     cdb_pkt,
    output logic                            can_load
);

    logic                        valid_q;
    core_types_pkg::cdb_packet_t pkt_q;
    core_types_pkg::bmask_t      bm_q;
    logic                        held_squash;
    logic                        in_squash;
    logic [`XLEN-1:0]            value_sel;

    assign held_squash = core_types_pkg::bm_squash(bm_q, branch_resolve);
    assign in_squash   = core_types_pkg::bm_squash(stage_in.bm, branch_resolve);

    // free slot, or the current result leaves on the bus at this edge
    assign can_load = ~valid_q | cdb_grant;

    // MUL returns the low word, all other variants the high word
    assign value_sel = (stage_in.func == mult_pkg::MUL) ? stage_in.sum.half.lo
                                                         : stage_in.sum.half.hi;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (can_load) begin
            valid_q <= stage_in.valid & ~in_squash;
        end else begin
            valid_q <= valid_q & ~held_squash;  // a waiting result can still be killed
        end
    end

    always_ff @(posedge clock) begin
        if (can_load) begin
            pkt_q.tag   <= stage_in.dest;
            pkt_q.value <= value_sel;
            bm_q        <= core_types_pkg::bm_clear(stage_in.bm, branch_resolve);
        end else begin
            bm_q <= core_types_pkg::bm_clear(bm_q, branch_resolve);
        end
    end

    assign cdb_req = valid_q;
    assign cdb_pkt = pkt_q;

    // the bus arbiter relies on a pending request not changing under it
    a_req_stable : assert property (
        @(posedge clock) disable iff (!arst_n)
        (cdb_req && !cdb_grant && !held_squash) |=> (cdb_req && $stable(cdb_pkt))
    ) else $error("CDB request or packet changed before grant");

endmodule

// ==== design/mult_stage.sv ====
`timescale 1ns/1ps
`include "mult_params.svh"

module mult_stage (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            advance,    // downstream takes our contents this edge
    input  mult_pkg::mult_stage_t           stage_in,
    input  core_types_pkg::branch_resolve_t branch_resolve,
    output mult_pkg::mult_stage_t           stage_out,
    output logic                            can_load
);

    // multiplier bits consumed per stage
    localparam int unsigned SHIFT = (2 * `XLEN) / `MULT_STAGES;

    logic                      valid_q;
    mult_pkg::mult_product_u   sum_q;
    logic [2*`XLEN-1:0]        mplier_q;
    logic [2*`XLEN-1:0]        mcand_q;
    core_types_pkg::phys_reg_t dest_q;
    core_types_pkg::bmask_t    bm_q;
    mult_pkg::mult_func_e      func_q;

    mult_pkg::mult_stage_t     src;         // packet that will sit here after the edge
    logic [2*`XLEN-1:0]        partial;

    assign can_load = advance | ~valid_q;   // either we move on or we hold nothing

    assign src = can_load ? stage_in : stage_out;

    // low chunk of the multiplier times the aligned multiplicand
    assign partial = stage_in.mplier[SHIFT-1:0] * stage_in.mcand;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= src.valid & ~core_types_pkg::bm_squash(src.bm, branch_resolve);
        end
    end

    always_ff @(posedge clock) begin
        if (can_load) begin
            sum_q.full <= stage_in.sum.full + partial;
            mplier_q   <= stage_in.mplier >> SHIFT;
            mcand_q    <= stage_in.mcand << SHIFT;
            dest_q     <= stage_in.dest;
            func_q     <= stage_in.func;
        end
        bm_q <= core_types_pkg::bm_clear(src.bm, branch_resolve);  // also while stalled
    end

    always_comb begin
        stage_out.valid  = valid_q;
        stage_out.sum    = sum_q;
        stage_out.mplier = mplier_q;
        stage_out.mcand  = mcand_q;
        stage_out.dest   = dest_q;
        stage_out.bm     = bm_q;
        stage_out.func   = func_q;
    end

    // the chunk width has to tile the product exactly or high bits get lost
    a_stage_count : assert property (
        @(posedge clock) ((2 * `XLEN) % `MULT_STAGES) == 0
    ) else $error("MULT_STAGES does not divide the product width");

    a_valid_known : assert property (
        @(posedge clock) disable iff (!arst_n) !$isunknown(valid_q)
    ) else $error("stage valid bit is X");

endmodule

// ==== design/mult_unit.sv ====
`timescale 1ns/1ps
`include "mult_params.svh"

module mult_unit (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            issue_valid,
    input  mult_pkg::mult_issue_t           issue_pkt,
    output logic                            issue_ready,
    input  core_types_pkg::branch_resolve_t branch_resolve,
    output logic                            cdb_req,
    input  logic                            cdb_grant,
    output core_types_pkg::cdb_packet_t     cdb_pkt
);

    // chain[0] comes from operand prep, chain[k+1] is the register of stage k
    mult_pkg::mult_stage_t [`MULT_STAGES:0] chain;

    // load_ok[k] says stage k loads at this edge, the top bit is the result stage
    logic [`MULT_STAGES:0] load_ok;

    mult_operand_prep u_prep (
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt),
        .branch_resolve (branch_resolve),
        .stage_pkt      (chain[0])
    );

    for (genvar k = 0; k < `MULT_STAGES; k++) begin : g_stage
        mult_stage u_stage (
            .clock          (clock),
            .arst_n         (arst_n),
            .advance        (load_ok[k+1]),     // the next stage takes our packet
            .stage_in       (chain[k]),
            .branch_resolve (branch_resolve),
            .stage_out      (chain[k+1]),
            .can_load       (load_ok[k])
        );
    end

    mult_result_stage u_result (
        .clock          (clock),
        .arst_n         (arst_n),
        .stage_in       (chain[`MULT_STAGES]),
        .branch_resolve (branch_resolve),
        .cdb_grant      (cdb_grant),
        .cdb_req        (cdb_req),
        .cdb_pkt        (cdb_pkt),
        .can_load       (load_ok[`MULT_STAGES])
    );

    // stage 0 can take a new packet whenever it is free or moving on
    assign issue_ready = load_ok[0];

endmodule

// ==== testbench/mult_unit_tb.sv ====
`timescale 1ns/1ps
`include "mult_params.svh"

module mult_unit_tb;

    localparam int GRANT_HIGH   = 0;
    localparam int GRANT_RANDOM = 1;
    localparam int GRANT_LOW    = 2;

    // directed, latency, throughput, back-pressure, squash and correct prediction
    localparam int N_OPS          = 100 + 1 + 16 + 60 + (`MULT_STAGES + 1) + `MULT_STAGES;
    localparam int TIMEOUT_CYCLES = N_OPS * (`MULT_STAGES + 4) + 200;

    typedef struct packed {
        core_types_pkg::phys_reg_t tag;
        logic [`XLEN-1:0]          value;
        core_types_pkg::bmask_t    bm;
    } exp_entry_t;

    logic                            clock = 1'b0;
    logic                            arst_n;
    logic                            issue_valid;
    mult_pkg::mult_issue_t           issue_pkt;
    logic                            issue_ready;
    core_types_pkg::branch_resolve_t branch_resolve;
    logic                            cdb_req;
    logic                            cdb_grant = 1'b1;
    core_types_pkg::cdb_packet_t     cdb_pkt;

    exp_entry_t exp_q[$];       // results still owed by the unit, oldest first
    exp_entry_t kept_q[$];
    int         xfer_cycles[$]; // cycle of every CDB transfer
    int         cycle_count = 0;
    int         grant_mode = GRANT_HIGH;
    int         next_tag = 0;

    mult_unit u_dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt),
        .issue_ready    (issue_ready),
        .branch_resolve (branch_resolve),
        .cdb_req        (cdb_req),
        .cdb_grant      (cdb_grant),
        .cdb_pkt        (cdb_pkt)
    );

    always #4 clock = ~clock;

    // RISC-V M semantics on full 64-bit signed products
    function automatic logic [`XLEN-1:0] ref_mult(input mult_pkg::mult_func_e f,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ua;
        logic signed [63:0] ub;
        logic signed [63:0] p;
        sa = $signed(a);
        sb = $signed(b);
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (f)
            mult_pkg::MUL:    p = sa * sb;
            mult_pkg::MULH:   p = sa * sb;
            mult_pkg::MULHSU: p = sa * ub;
            default:          p = ua * ub;
        endcase
        return (f == mult_pkg::MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [`XLEN-1:0] corner_value(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // br goes out in the same cycle as the packet, so it sees the packet as issued
    task automatic issue_op(input mult_pkg::mult_func_e f, input logic [`XLEN-1:0] a,
                            input logic [`XLEN-1:0] b, input core_types_pkg::bmask_t bm,
                            input core_types_pkg::branch_resolve_t br, output int stalls);
        logic accepted;
        stalls   = 0;
        accepted = 1'b0;
        @(negedge clock);
        issue_valid         = 1'b1;
        issue_pkt.src1      = a;
        issue_pkt.src2      = b;
        issue_pkt.func      = f;
        issue_pkt.dest      = next_tag[$clog2(`PHYS_REGS)-1:0];
        issue_pkt.bm        = bm;
        branch_resolve      = br;
        next_tag            = (next_tag + 1) % `PHYS_REGS;
        while (!accepted) begin
            @(posedge clock);
            accepted = issue_ready;
            if (!accepted) begin
                stalls++;
                @(negedge clock);
                branch_resolve = '0;    // one broadcast per resolve
            end
        end
    endtask

    task automatic issue_random(input core_types_pkg::bmask_t bm,
                                input core_types_pkg::branch_resolve_t br, output int stalls);
        issue_op(mult_pkg::mult_func_e'($urandom_range(3, 0)), $urandom, $urandom, bm, br, stalls);
    endtask

    task automatic stop_issue();
        @(negedge clock);
        issue_valid    = 1'b0;
        branch_resolve = '0;
    endtask

    task automatic resolve_only(input core_types_pkg::branch_resolve_t br);
        @(negedge clock);
        issue_valid    = 1'b0;
        branch_resolve = br;
    endtask

    task automatic set_grant(input int mode);
        @(posedge clock);
        grant_mode = mode;
    endtask

    task automatic wait_drain();
        stop_issue();
        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
    endtask

    always @(negedge clock) begin
        case (grant_mode)
            GRANT_RANDOM: cdb_grant = $urandom_range(1, 0);   // gaps on about half the cycles
            GRANT_LOW:    cdb_grant = 1'b0;
            default:      cdb_grant = 1'b1;
        endcase
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the unit stopped making progress", cycle_count);
            abort_run();
        end
    end

    // a granted result leaves before the broadcast can touch it
    always @(posedge clock) begin : scoreboard
        exp_entry_t head;
        exp_entry_t entry;
        if (arst_n) begin
            if (!issue_ready) begin
                check_value(exp_q.size(), `MULT_STAGES + 1, "packets held while issue_ready low");
            end
            if (cdb_req && cdb_grant) begin
                if (exp_q.size() == 0) begin
                    $display("the CDB delivered tag %0d while no result was expected", cdb_pkt.tag);
                    abort_run();
                end else begin
                    head = exp_q.pop_front();
                    check_value(cdb_pkt.tag, head.tag, "CDB tag");
                    check_value(cdb_pkt.value, head.value, "CDB value");
                    xfer_cycles.push_back(cycle_count);
                end
            end
            if (issue_valid && issue_ready) begin
                entry.tag   = issue_pkt.dest;
                entry.value = ref_mult(issue_pkt.func, issue_pkt.src1, issue_pkt.src2);
                entry.bm    = issue_pkt.bm;
                exp_q.push_back(entry);
            end
            if (branch_resolve.valid) begin
                kept_q = {};
                foreach (exp_q[i]) begin
                    entry = exp_q[i];
                    if (!(branch_resolve.mispredict &&
                          |(entry.bm & branch_resolve.branch_bit))) begin
                        if (!branch_resolve.mispredict) begin
                            entry.bm = entry.bm & ~branch_resolve.branch_bit;
                        end
                        kept_q.push_back(entry);
                    end
                end
                exp_q = kept_q;
            end
        end
    end

    initial begin
        int                              seed_draw;
        int                              stalls;
        int                              edges;
        int                              first;
        int                              squash_hits;
        core_types_pkg::bmask_t          bm;
        core_types_pkg::branch_resolve_t br;

        seed_draw      = $urandom(32'haaed);
        arst_n         = 1'b0;
        issue_valid    = 1'b0;
        issue_pkt      = '0;
        branch_resolve = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        check_value(issue_ready, 1'b1, "issue_ready after reset");
        check_value(cdb_req, 1'b0, "cdb_req after reset");

        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_op(mult_pkg::mult_func_e'(f), corner_value(i), corner_value(j),
                             '0, '0, stalls);
                end
            end
        end
        wait_drain();

        // the issue edge loads stage 0 and counts as the first register
        issue_random('0, '0, stalls);
        stop_issue();
        edges = 1;
        while (!cdb_req) begin
            @(negedge clock);
            edges++;
        end
        check_value(edges, `MULT_STAGES + 1, "register edges from issue to cdb_req");
        wait_drain();

        first = xfer_cycles.size();
        for (int i = 0; i < 16; i++) begin
            issue_random('0, '0, stalls);
            check_value(stalls, 0, "issue stalls with grant held high");
        end
        wait_drain();
        check_value(xfer_cycles.size() - first, 16, "results from back-to-back issue");
        check_value(xfer_cycles[first + 15] - xfer_cycles[first], 15, "cycles spanned by 16 results");

        set_grant(GRANT_RANDOM);
        for (int i = 0; i < 60; i++) begin
            issue_random('0, '0, stalls);
        end
        wait_drain();

        // the packets ahead back up behind the blocked result stage
        // and the last one rides in with the misprediction
        set_grant(GRANT_LOW);
        wait_drain();
        first       = xfer_cycles.size();
        squash_hits = 0;
        for (int i = 0; i <= `MULT_STAGES; i++) begin
            br = '0;
            if (i == `MULT_STAGES || i % 2 == 0) begin
                bm = core_types_pkg::bmask_t'(1);
                squash_hits++;
            end else begin
                bm = core_types_pkg::bmask_t'(2);
            end
            if (i == `MULT_STAGES) begin
                br.valid      = 1'b1;
                br.mispredict = 1'b1;
                br.branch_bit = core_types_pkg::bmask_t'(1);
                stop_issue();   // one idle cycle so every packet ahead is stalled
            end
            issue_random(bm, br, stalls);
        end
        stop_issue();
        set_grant(GRANT_HIGH);
        wait_drain();
        check_value(xfer_cycles.size() - first, `MULT_STAGES + 1 - squash_hits,
                    "results left after misprediction");

        set_grant(GRANT_LOW);
        first = xfer_cycles.size();
        for (int i = 0; i < `MULT_STAGES; i++) begin
            bm = (i == `MULT_STAGES - 1) ? '0 : core_types_pkg::bmask_t'(4);
            issue_random(bm, '0, stalls);
        end
        br.valid      = 1'b1;
        br.mispredict = 1'b0;
        br.branch_bit = core_types_pkg::bmask_t'(4);
        resolve_only(br);
        br.mispredict = 1'b1;       // same branch slot, now reused by a newer branch
        resolve_only(br);
        stop_issue();
        set_grant(GRANT_HIGH);

        // with the grant held high the backed-up results leave one per cycle
        repeat (`MULT_STAGES + 4) @(negedge clock);
        check_value(xfer_cycles.size() - first, `MULT_STAGES, "results after correct prediction");

        if (exp_q.size() != 0) begin
            $display("run ended with %0d expected results never delivered", exp_q.size());
            abort_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule
